//--- rtl/mem_test_settings.svh
// Memory traffic generator settings
`ifndef MEM_TEST_SETTINGS_SVH
`define MEM_TEST_SETTINGS_SVH

// Cache-line address width
`define MT_ADDR_BITS 42

// Request tag width
`define MT_MDATA_BITS 16

// One line of data
`define MT_LINE_BITS 512

// Counter width, events are at most one per cycle
`define MT_CNT_BITS 32

// CSRs on both the write and read side
`define MT_NUM_CSRS 8

// Log2 of the host buffer size, reported in CSR 0
`define MT_REGION_BITS 24

`endif

//--- rtl/mem_chan_pkg.sv
// Memory channel types
`include "mem_test_settings.svh"

package mem_chan_pkg;

    typedef logic [`MT_ADDR_BITS-1:0] t_line_addr;
    typedef logic [`MT_MDATA_BITS-1:0] t_mdata;
    typedef logic [`MT_LINE_BITS-1:0] t_line_data;

    // Read request channel, one line per request
    typedef struct packed {
        logic valid;
        t_line_addr addr;
        t_mdata tag;
    } t_rd_req;

    // Write request channel
    typedef struct packed {
        logic valid;
        t_line_addr addr;
        t_mdata tag;
        t_line_data data;
    } t_wr_req;

    // Response strobe, same shape on both channels
    typedef struct packed {
        logic valid;
        t_mdata tag;
    } t_mem_rsp;

    // Stream output, offset still relative to its buffer base
    typedef struct packed {
        logic valid;
        t_line_addr offset;
        t_mdata tag;
    } t_stream_req;

endpackage

//--- rtl/test_csr_pkg.sv
// CSR and run state types
`include "mem_test_settings.svh"

package test_csr_pkg;

    typedef logic [`MT_CNT_BITS-1:0] t_counter;
    typedef logic [15:0] t_stride;

    typedef enum logic [1:0]
    {
        STATE_IDLE,
        STATE_RUN,
        STATE_TERMINATE
    } t_run_state;

    // One host CSR write, valid for a single cycle
    typedef struct packed {
        logic enable;
        logic [$clog2(`MT_NUM_CSRS)-1:0] index;
        logic [63:0] data;
    } t_csr_wr;

    // CSR 5 layout
    typedef struct packed {
        logic [45:0] reserved;
        t_stride stride;
        logic enable_writes;
        logic enable_reads;
    } t_csr_mode;

    // CSR 6 layout, offered-load intervals
    typedef struct packed {
        logic [47:0] reserved;
        logic [7:0] wr_interval;
        logic [7:0] rd_interval;
    } t_csr_pacing;

    typedef union packed {
        t_csr_mode mode;
        t_csr_pacing pacing;
    } t_csr_word;

    // Per-stream configuration
    typedef struct packed {
        t_stride stride;
        mem_chan_pkg::t_line_addr mask;
        logic [7:0] interval;
        logic enable;
    } t_stream_cfg;

endpackage

//--- rtl/csr_block.sv
// CSR storage and read-back
`timescale 1ns/100ps
`include "mem_test_settings.svh"

module csr_block
(
    input  logic clk,
    input  logic reset,
    input  test_csr_pkg::t_csr_wr csr_wr,
    input  logic [$clog2(`MT_NUM_CSRS)-1:0] csr_rd_index,
    input  test_csr_pkg::t_run_state run_state,
    input  logic rd_almost_full,
    input  logic wr_almost_full,
    input  test_csr_pkg::t_counter rd_count,
    input  test_csr_pkg::t_counter wr_count,
    output logic [63:0] csr_rd_data,
    output logic start,
    output logic run_expired,
    output mem_chan_pkg::t_line_addr status_addr,
    output mem_chan_pkg::t_line_addr rd_base,
    output mem_chan_pkg::t_line_addr wr_base,
    output test_csr_pkg::t_stream_cfg rd_cfg,
    output test_csr_pkg::t_stream_cfg wr_cfg
);
    import mem_chan_pkg::*;
    import test_csr_pkg::*;

    t_line_addr mem_mask;
    t_csr_word csr_mode;
    t_csr_word csr_pacing;
    t_counter cycles_rem;

    // ========================================
    // Configuration capture
    // ========================================

    always_ff @(posedge clk)
    begin
        if (csr_wr.enable)
        begin
            case (csr_wr.index)
                1: status_addr <= t_line_addr'(csr_wr.data);
                2: rd_base <= t_line_addr'(csr_wr.data);
                3: wr_base <= t_line_addr'(csr_wr.data);
                4: mem_mask <= t_line_addr'(csr_wr.data);
                5: csr_mode <= csr_wr.data;
                6: csr_pacing <= csr_wr.data;
                default: ;
            endcase
        end

        // Enables and intervals come up cleared
        if (reset)
        begin
            csr_mode <= '0;
            csr_pacing <= '0;
        end
    end

    // Mode view for CSR 5, pacing view for CSR 6
    always_comb
    begin
        rd_cfg.stride = csr_mode.mode.stride;
        rd_cfg.mask = mem_mask;
        rd_cfg.interval = csr_pacing.pacing.rd_interval;
        rd_cfg.enable = csr_mode.mode.enable_reads;

        wr_cfg.stride = csr_mode.mode.stride;
        wr_cfg.mask = mem_mask;
        wr_cfg.interval = csr_pacing.pacing.wr_interval;
        wr_cfg.enable = csr_mode.mode.enable_writes;
    end

    // ========================================
    // Run length
    // ========================================

    always_ff @(posedge clk)
    begin
        // Count down to zero and hold there
        if (cycles_rem != t_counter'(0))
        begin
            cycles_rem <= cycles_rem - t_counter'(1);
        end

        // CSR 0 loads the length and kicks off a run
        if (csr_wr.enable && (csr_wr.index == 0))
        begin
            cycles_rem <= t_counter'(csr_wr.data);
        end
        start <= csr_wr.enable && (csr_wr.index == 0);

        if (reset)
        begin
            cycles_rem <= t_counter'(0);
            start <= 1'b0;
        end
    end

    assign run_expired = (cycles_rem == t_counter'(0));

    // ========================================
    // Read-back
    // ========================================

    always_comb
    begin
        case (csr_rd_index)
            0: csr_rd_data = 64'(`MT_REGION_BITS);
            1: csr_rd_data = 64'(status_addr);
            2: csr_rd_data = 64'(rd_base);
            3: csr_rd_data = 64'(wr_base);
            4: csr_rd_data = 64'(rd_count);
            5: csr_rd_data = 64'(wr_count);
            // State in 9:8, almost-full levels in 1:0
            7: csr_rd_data = {54'(0), run_state, 6'(0), wr_almost_full, rd_almost_full};
            default: csr_rd_data = 64'(0);
        endcase
    end

endmodule

//--- rtl/run_control.sv
// Run state machine
`timescale 1ns/100ps

module run_control
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic run_expired,
    input  logic cfg_rd_en,
    input  logic cfg_wr_en,
    input  logic status_sent,
    output test_csr_pkg::t_run_state run_state,
    output logic rd_enable,
    output logic wr_enable,
    output test_csr_pkg::t_counter cycles_executed
);
    import test_csr_pkg::*;

    always_ff @(posedge clk)
    begin
        case (run_state)
            STATE_IDLE:
            begin
                // Enables are sampled once per run
                if (start)
                begin
                    run_state <= STATE_RUN;
                    rd_enable <= cfg_rd_en;
                    wr_enable <= cfg_wr_en;
                end
                cycles_executed <= t_counter'(0);
            end

            STATE_RUN:
            begin
                // Out of cycles, stop both streams
                if (run_expired)
                begin
                    run_state <= STATE_TERMINATE;
                    rd_enable <= 1'b0;
                    wr_enable <= 1'b0;
                end
                cycles_executed <= cycles_executed + t_counter'(1);
            end

            STATE_TERMINATE:
            begin
                // Drain time counts toward the run
                if (status_sent)
                begin
                    run_state <= STATE_IDLE;
                end
                cycles_executed <= cycles_executed + t_counter'(1);
            end

            default:
            begin
                run_state <= STATE_IDLE;
            end
        endcase

        if (reset)
        begin
            run_state <= STATE_IDLE;
            rd_enable <= 1'b0;
            wr_enable <= 1'b0;
            cycles_executed <= t_counter'(0);
        end
    end

endmodule

//--- rtl/traffic_stream.sv
// Paced strided request stream
`timescale 1ns/100ps

module traffic_stream
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic enable,
    input  logic almost_full,
    input  test_csr_pkg::t_stream_cfg cfg,
    output mem_chan_pkg::t_stream_req req
);
    import mem_chan_pkg::*;
    import test_csr_pkg::*;

    logic af_q;
    logic [7:0] pace_cnt;
    logic pace_ok;
    logic do_issue;

    t_line_addr offset;
    t_line_addr offset_next;
    t_stride base_cur;
    t_stride base_max;
    t_stride base_wrap;
    logic overflow;
    t_mdata tag;

    // ========================================
    // Throttling and pacing
    // ========================================

    always_ff @(posedge clk)
    begin
        af_q <= almost_full;

        // Open one slot every interval+1 cycles
        pace_ok <= (pace_cnt == 8'd0);
        pace_cnt <= pace_cnt - 8'd1;
        if (pace_cnt == 8'd0)
        begin
            pace_cnt <= cfg.interval;
        end

        // Treat the channel as full until proven otherwise
        if (reset)
        begin
            af_q <= 1'b1;
            pace_cnt <= 8'd0;
            pace_ok <= 1'b0;
        end
    end

    // Live mode bit can pause a stream mid-run
    assign do_issue = enable && cfg.enable && !af_q && pace_ok;

    // ========================================
    // Strided walker
    // ========================================

    always_comb
    begin
        // Largest rotating base, one line below the stride, kept inside the region
        base_max = (cfg.stride == t_stride'(0)) ?
                   t_stride'(0) : ((cfg.stride - t_stride'(1)) & t_stride'(cfg.mask));
        base_wrap = (base_cur < base_max) ? (base_cur + t_stride'(1)) : t_stride'(0);

        // Next line falls outside the region
        overflow = |(offset_next & ~cfg.mask);
    end

    always_ff @(posedge clk)
    begin
        if (do_issue)
        begin
            tag <= tag + t_mdata'(1);
            if (overflow)
            begin
                // Back to the head at a shifted base, so every
                // stride covers the same footprint
                offset <= t_line_addr'(base_wrap);
                offset_next <= t_line_addr'(base_wrap) + t_line_addr'(cfg.stride);
                base_cur <= base_wrap;
            end
            else
            begin
                offset <= offset_next;
                offset_next <= offset_next + t_line_addr'(cfg.stride);
            end
        end

        // Fresh walk for every run
        if (reset || start)
        begin
            offset <= t_line_addr'(0);
            offset_next <= t_line_addr'(cfg.stride);
            base_cur <= t_stride'(0);
            tag <= t_mdata'(0);
        end
    end

    always_comb
    begin
        req.valid = do_issue;
        req.offset = offset;
        req.tag = tag;
    end

endmodule

//--- rtl/status_writer.sv
// Request channel output and status write
`timescale 1ns/100ps

module status_writer
(
    input  logic clk,
    input  logic reset,
    input  test_csr_pkg::t_run_state run_state,
    input  mem_chan_pkg::t_stream_req rd_stream,
    input  mem_chan_pkg::t_stream_req wr_stream,
    input  mem_chan_pkg::t_line_addr rd_base,
    input  mem_chan_pkg::t_line_addr wr_base,
    input  mem_chan_pkg::t_line_addr status_addr,
    input  test_csr_pkg::t_counter cycles_executed,
    input  test_csr_pkg::t_counter rd_count,
    input  test_csr_pkg::t_counter wr_count,
    input  logic wr_almost_full,
    input  logic rd_pending,
    input  logic wr_pending,
    output mem_chan_pkg::t_rd_req rd_req,
    output mem_chan_pkg::t_wr_req wr_req,
    output logic status_sent
);
    import mem_chan_pkg::*;
    import test_csr_pkg::*;

    logic wr_af_q;
    logic do_status;

    // Everything drained, both channels idle, room on the write side
    assign do_status = (run_state == STATE_TERMINATE) && !wr_af_q &&
                       !rd_pending && !wr_pending &&
                       !rd_req.valid && !wr_req.valid;

    // ========================================
    // Channel registers
    // ========================================

    always_ff @(posedge clk)
    begin
        wr_af_q <= wr_almost_full;

        rd_req.valid <= rd_stream.valid;
        rd_req.addr <= rd_base + rd_stream.offset;
        rd_req.tag <= rd_stream.tag;

        wr_req.valid <= wr_stream.valid;
        wr_req.addr <= wr_base + wr_stream.offset;
        wr_req.tag <= wr_stream.tag;
        wr_req.data <= t_line_data'(0);

        // Write stream is already stopped, so the status line just takes the slot
        if (do_status)
        begin
            wr_req.valid <= 1'b1;
            wr_req.addr <= status_addr;
            wr_req.tag <= t_mdata'(0);
            wr_req.data <= t_line_data'({wr_count, rd_count, cycles_executed});
        end
        status_sent <= do_status;

        if (reset)
        begin
            wr_af_q <= 1'b1;
            rd_req.valid <= 1'b0;
            wr_req.valid <= 1'b0;
            status_sent <= 1'b0;
        end
    end

endmodule

//--- rtl/response_counters.sv
// Response counters
`timescale 1ns/100ps

module response_counters
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  mem_chan_pkg::t_mem_rsp rd_rsp,
    input  mem_chan_pkg::t_mem_rsp wr_rsp,
    output test_csr_pkg::t_counter rd_count,
    output test_csr_pkg::t_counter wr_count
);
    import test_csr_pkg::*;

    logic rd_seen;
    logic wr_seen;

    always_ff @(posedge clk)
    begin
        // Strobes staged once off the shell
        rd_seen <= rd_rsp.valid;
        wr_seen <= wr_rsp.valid;

        if (rd_seen)
        begin
            rd_count <= rd_count + t_counter'(1);
        end
        if (wr_seen)
        begin
            wr_count <= wr_count + t_counter'(1);
        end

        // Counts are per run
        if (reset || start)
        begin
            rd_seen <= 1'b0;
            wr_seen <= 1'b0;
            rd_count <= t_counter'(0);
            wr_count <= t_counter'(0);
        end
    end

endmodule

//--- rtl/mem_test_top.sv
// Memory traffic generator top
`timescale 1ns/100ps
`include "mem_test_settings.svh"

module mem_test_top
(
    input  logic clk,
    input  logic reset,
    input  test_csr_pkg::t_csr_wr csr_wr,
    input  logic [$clog2(`MT_NUM_CSRS)-1:0] csr_rd_index,
    output logic [63:0] csr_rd_data,
    output mem_chan_pkg::t_rd_req rd_req,
    input  mem_chan_pkg::t_mem_rsp rd_rsp,
    output mem_chan_pkg::t_wr_req wr_req,
    input  mem_chan_pkg::t_mem_rsp wr_rsp,
    input  logic rd_almost_full,
    input  logic wr_almost_full,
    input  logic rd_pending,
    input  logic wr_pending
);
    import mem_chan_pkg::*;
    import test_csr_pkg::*;

    // Configuration and run control
    logic start;
    logic run_expired;
    t_line_addr status_addr;
    t_line_addr rd_base;
    t_line_addr wr_base;
    t_stream_cfg rd_cfg;
    t_stream_cfg wr_cfg;
    t_run_state run_state;
    logic rd_enable;
    logic wr_enable;
    t_counter cycles_executed;

    // Datapath
    t_stream_req rd_stream;
    t_stream_req wr_stream;
    logic status_sent;
    t_counter rd_count;
    t_counter wr_count;

    csr_block u_csr_block
    (
        .clk, .reset, .csr_wr, .csr_rd_index, .run_state,
        .rd_almost_full, .wr_almost_full, .rd_count, .wr_count,
        .csr_rd_data, .start, .run_expired, .status_addr,
        .rd_base, .wr_base, .rd_cfg, .wr_cfg
    );

    run_control u_run_control
    (
        .clk, .reset, .start, .run_expired,
        .cfg_rd_en(rd_cfg.enable), .cfg_wr_en(wr_cfg.enable), .status_sent,
        .run_state, .rd_enable, .wr_enable, .cycles_executed
    );

    traffic_stream u_rd_stream
    (
        .clk, .reset, .start, .enable(rd_enable),
        .almost_full(rd_almost_full), .cfg(rd_cfg), .req(rd_stream)
    );

    traffic_stream u_wr_stream
    (
        .clk, .reset, .start, .enable(wr_enable),
        .almost_full(wr_almost_full), .cfg(wr_cfg), .req(wr_stream)
    );

    status_writer u_status_writer
    (
        .clk, .reset, .run_state, .rd_stream, .wr_stream,
        .rd_base, .wr_base, .status_addr, .cycles_executed,
        .rd_count, .wr_count, .wr_almost_full, .rd_pending, .wr_pending,
        .rd_req, .wr_req, .status_sent
    );

    response_counters u_response_counters
    (
        .clk, .reset, .start, .rd_rsp, .wr_rsp, .rd_count, .wr_count
    );

endmodule

//--- verification/mem_test_sva.sv
// Memory traffic generator checks
`timescale 1ns/100ps

module mem_test_checks
(
    input  logic clk,
    input  logic reset,
    input  mem_chan_pkg::t_rd_req rd_req,
    input  mem_chan_pkg::t_wr_req wr_req,
    input  logic rd_almost_full,
    input  logic wr_almost_full,
    input  logic [7:0] rd_interval,
    input  mem_chan_pkg::t_line_addr status_addr,
    input  test_csr_pkg::t_run_state run_state
);
    import test_csr_pkg::*;

    // Count of failed assertions
    int fail_count = 0;

    // Saturating count of cycles since the last read request
    logic [8:0] rd_gap;

    always_ff @(posedge clk)
    begin
        if (rd_req.valid)
        begin
            rd_gap <= 9'd0;
        end
        else if (rd_gap != 9'h1ff)
        begin
            rd_gap <= rd_gap + 9'd1;
        end

        if (reset)
        begin
            rd_gap <= 9'h1ff;
        end
    end

    // ========================================
    // Pacing and back-pressure
    // ========================================

    // Interval N leaves at least N idle cycles between reads
    rd_pacing: assert property (@(posedge clk) disable iff (reset)
        rd_req.valid |-> (rd_gap >= 9'(rd_interval)))
    else
    begin
        fail_count++;
        $error("read requests closer than the pacing interval");
    end

    // Three cycles of almost-full stop the read channel
    rd_throttle: assert property (@(posedge clk) disable iff (reset)
        (rd_almost_full && $past(rd_almost_full) && $past(rd_almost_full, 2)) |-> !rd_req.valid)
    else
    begin
        fail_count++;
        $error("read request issued under almost-full");
    end

    // Same rule on the write channel including the status line
    wr_throttle: assert property (@(posedge clk) disable iff (reset)
        (wr_almost_full && $past(wr_almost_full) && $past(wr_almost_full, 2)) |-> !wr_req.valid)
    else
    begin
        fail_count++;
        $error("write request issued under almost-full");
    end

    // ========================================
    // Run control
    // ========================================

    // Status line only while terminating
    status_in_terminate: assert property (@(posedge clk) disable iff (reset)
        (wr_req.valid && (wr_req.addr == status_addr)) |-> (run_state == STATE_TERMINATE))
    else
    begin
        fail_count++;
        $error("status write outside the terminate state");
    end

    // Run drops back to idle in the cycle after its status line
    status_ends_run: assert property (@(posedge clk) disable iff (reset)
        (wr_req.valid && (wr_req.addr == status_addr)) |=> (run_state == STATE_IDLE))
    else
    begin
        fail_count++;
        $error("run did not return to idle after the status write");
    end

endmodule

bind mem_test_top mem_test_checks u_checks
(
    .clk, .reset, .rd_req, .wr_req, .rd_almost_full, .wr_almost_full,
    .rd_interval(rd_cfg.interval), .status_addr, .run_state
);

//--- verification/mem_test_tb.sv
// Memory traffic generator testbench
`timescale 1ns/100ps

module mem_test_tb;
    import mem_chan_pkg::*;
    import test_csr_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int LEN_A = 300;
    localparam int LEN_B = 400;
    localparam int LEN_C = 250;
    localparam int DRAIN_CYCLES = 200;
    localparam int CYCLE_LIMIT = RESET_CYCLES + LEN_A + LEN_B + LEN_C + 3 * DRAIN_CYCLES;

    // Buffers far apart, status line outside both
    localparam t_line_addr RD_BASE = 42'h1_0000;
    localparam t_line_addr WR_BASE = 42'h2_0000;
    localparam t_line_addr STATUS_ADDR = 42'h3_0000;

    // One answer the responder still owes
    typedef struct packed {
        logic [31:0] due;
        t_mdata tag;
    } t_owed;

    // Reference walker position
    typedef struct packed {
        t_line_addr offset;
        t_stride base;
    } t_walk;

    logic clk = 1'b0;
    logic reset;
    t_csr_wr csr_wr;
    logic [2:0] csr_rd_index;
    logic [63:0] csr_rd_data;
    t_rd_req rd_req;
    t_mem_rsp rd_rsp;
    t_wr_req wr_req;
    t_mem_rsp wr_rsp;
    logic rd_almost_full;
    logic wr_almost_full;
    logic rd_pending;
    logic wr_pending;

    int seed = 32'ha0627393;
    int cyc = 0;
    int value_errors = 0;

    // Responder state
    t_owed rd_q[$];
    t_owed wr_q[$];
    int rd_hold = 0;
    int wr_hold = 0;
    int rd_rsp_total = 0;
    int wr_rsp_total = 0;
    logic af_on = 1'b0;

    // Current run
    t_stride run_stride;
    t_line_addr run_mask;
    logic run_wr_en;
    int run_len;
    int rd_start_count;
    int wr_start_count;
    int status_seen;
    t_walk rd_walk;
    t_walk wr_walk;

    mem_test_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) cyc = cyc + 1;

    // ========================================
    // Reference model and reporting
    // ========================================

    // Next line of a strided walk, back to a rotating base past the mask
    function automatic t_walk walk_step(t_walk w, t_stride stride, t_line_addr mask);
        t_walk n;
        t_line_addr ahead;
        t_stride top;
        n = w;
        ahead = w.offset + t_line_addr'(stride);
        top = (stride == 0) ? t_stride'(0) : ((stride - t_stride'(1)) & t_stride'(mask));
        if ((ahead & ~mask) != 0)
        begin
            n.base = (w.base < top) ? (w.base + t_stride'(1)) : t_stride'(0);
            n.offset = t_line_addr'(n.base);
        end
        else
        begin
            n.offset = ahead;
        end
        return n;
    endfunction

    task automatic note_mismatch(string what, logic [63:0] got, logic [63:0] exp);
        value_errors++;
        $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    // ========================================
    // Request monitor
    // ========================================

    always @(negedge clk)
    begin : monitor
        t_owed owed;
        if (!reset)
        begin
            if (rd_req.valid)
            begin
                assert (rd_req.addr == RD_BASE + rd_walk.offset)
                else note_mismatch("read address", 64'(rd_req.addr), 64'(RD_BASE + rd_walk.offset));
                rd_walk = walk_step(rd_walk, run_stride, run_mask);
                owed.due = 32'(cyc + 1 + ($random(seed) & 15));
                owed.tag = rd_req.tag;
                rd_q.push_back(owed);
            end
            if (wr_req.valid)
            begin
                if (wr_req.addr == STATUS_ADDR)
                begin
                    // Counts in the line cover everything answered so far
                    status_seen++;
                    assert (wr_req.data[31:0] >= 32'(run_len))
                    else note_mismatch("status cycle count", 64'(wr_req.data[31:0]), 64'(run_len));
                    assert (wr_req.data[63:32] == 32'(rd_rsp_total - rd_start_count))
                    else note_mismatch("status read count", 64'(wr_req.data[63:32]),
                                       64'(rd_rsp_total - rd_start_count));
                    assert (wr_req.data[95:64] == 32'(wr_rsp_total - wr_start_count))
                    else note_mismatch("status write count", 64'(wr_req.data[95:64]),
                                       64'(wr_rsp_total - wr_start_count));
                end
                else
                begin
                    assert (run_wr_en)
                    else note_mismatch("write enable of a run with a stream write", 0, 1);
                    assert (wr_req.addr == WR_BASE + wr_walk.offset)
                    else note_mismatch("write address", 64'(wr_req.addr),
                                       64'(WR_BASE + wr_walk.offset));
                    wr_walk = walk_step(wr_walk, run_stride, run_mask);
                end
                owed.due = 32'(cyc + 1 + ($random(seed) & 15));
                owed.tag = wr_req.tag;
                wr_q.push_back(owed);
            end
        end
    end

    // ========================================
    // Memory responder
    // ========================================

    initial
    begin : responder
        t_owed owed;
        rd_rsp = '0;
        wr_rsp = '0;
        rd_almost_full = 1'b0;
        wr_almost_full = 1'b0;
        rd_pending = 1'b0;
        wr_pending = 1'b0;
        forever
        begin
            @(posedge clk);
            #0.5;
            // One answer per channel per cycle, oldest first
            rd_rsp = '0;
            if ((rd_q.size() != 0) && (rd_q[0].due <= 32'(cyc)))
            begin
                owed = rd_q.pop_front();
                rd_rsp.valid = 1'b1;
                rd_rsp.tag = owed.tag;
                rd_rsp_total++;
                rd_hold = 3;
            end
            else if (rd_hold != 0)
            begin
                rd_hold--;
            end
            wr_rsp = '0;
            if ((wr_q.size() != 0) && (wr_q[0].due <= 32'(cyc)))
            begin
                owed = wr_q.pop_front();
                wr_rsp.valid = 1'b1;
                wr_rsp.tag = owed.tag;
                wr_rsp_total++;
                wr_hold = 3;
            end
            else if (wr_hold != 0)
            begin
                wr_hold--;
            end
            // Pending covers the counter pipeline behind the last answer
            rd_pending = (rd_q.size() != 0) || (rd_hold != 0);
            wr_pending = (wr_q.size() != 0) || (wr_hold != 0);

            if (af_on)
            begin
                if (($random(seed) & 15) == 0)
                begin
                    rd_almost_full = !rd_almost_full;
                end
                if (($random(seed) & 15) == 0)
                begin
                    wr_almost_full = !wr_almost_full;
                end
            end
            else
            begin
                rd_almost_full = 1'b0;
                wr_almost_full = 1'b0;
            end
        end
    end

    // ========================================
    // CSR access and runs
    // ========================================

    task automatic csr_write(logic [2:0] index, logic [63:0] data);
        @(posedge clk);
        #0.5;
        csr_wr.enable = 1'b1;
        csr_wr.index = index;
        csr_wr.data = data;
        @(posedge clk);
        #0.5;
        csr_wr = '0;
    endtask

    task automatic csr_read(logic [2:0] index, output logic [63:0] data);
        @(posedge clk);
        #0.5;
        csr_rd_index = index;
        #1;
        data = csr_rd_data;
    endtask

    task automatic run_test(int len, t_stride stride, t_line_addr mask, logic [7:0] rd_int,
                            logic [7:0] wr_int, logic rd_en, logic wr_en);
        t_csr_word mode_word;
        t_csr_word pace_word;
        logic [63:0] rdata;
        run_len = len;
        run_stride = stride;
        run_mask = mask;
        run_wr_en = wr_en;
        rd_walk = '0;
        wr_walk = '0;
        status_seen = 0;
        rd_start_count = rd_rsp_total;
        wr_start_count = wr_rsp_total;

        mode_word = '0;
        mode_word.mode.stride = stride;
        mode_word.mode.enable_writes = wr_en;
        mode_word.mode.enable_reads = rd_en;
        pace_word = '0;
        pace_word.pacing.wr_interval = wr_int;
        pace_word.pacing.rd_interval = rd_int;

        csr_write(3'd1, 64'(STATUS_ADDR));
        csr_write(3'd2, 64'(RD_BASE));
        csr_write(3'd3, 64'(WR_BASE));
        csr_write(3'd4, 64'(mask));
        csr_write(3'd5, mode_word);
        csr_write(3'd6, pace_word);
        af_on = 1'b1;
        csr_write(3'd0, 64'(len));

        // Back-pressure only while the streams run
        repeat (len + 2) @(posedge clk);
        af_on = 1'b0;
        while (status_seen == 0) @(posedge clk);
        while ((rd_q.size() != 0) || (wr_q.size() != 0) || (rd_hold != 0) || (wr_hold != 0))
        begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        assert (status_seen == 1)
        else note_mismatch("status lines in the run", 64'(status_seen), 1);
        csr_read(3'd4, rdata);
        assert (rdata == 64'(rd_rsp_total - rd_start_count))
        else note_mismatch("CSR 4", rdata, 64'(rd_rsp_total - rd_start_count));
        csr_read(3'd5, rdata);
        assert (rdata == 64'(wr_rsp_total - wr_start_count))
        else note_mismatch("CSR 5", rdata, 64'(wr_rsp_total - wr_start_count));
        csr_read(3'd7, rdata);
        assert (rdata[9:8] == 2'b00)
        else note_mismatch("CSR 7 run state", 64'(rdata[9:8]), 0);
    endtask

    initial
    begin
        reset = 1'b1;
        csr_wr = '0;
        csr_rd_index = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        reset = 1'b0;

        // Reads only, tight mask so the base rotates often
        run_test(LEN_A, 16'd3, 42'h3f, 8'd2, 8'd0, 1'b1, 1'b0);
        run_test(LEN_B, 16'd5, 42'hff, 8'd0, 8'd1, 1'b1, 1'b1);
        run_test(LEN_C, 16'd3, 42'h1f, 8'd4, 8'd3, 1'b1, 1'b1);

        $display("Errors: %0d value, %0d assertion", value_errors, UUT.u_checks.fail_count);
        if ((value_errors == 0) && (UUT.u_checks.fail_count == 0))
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog over all runs
    initial
    begin
        while (cyc < CYCLE_LIMIT) @(negedge clk);
        $display("Timeout after %0d cycles, a run never finished", cyc);
        $display("Errors: %0d value, %0d assertion", value_errors, UUT.u_checks.fail_count);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/mem_chan_pkg.sv
rtl/test_csr_pkg.sv
rtl/csr_block.sv
rtl/run_control.sv
rtl/traffic_stream.sv
rtl/status_writer.sv
rtl/response_counters.sv
rtl/mem_test_top.sv
verification/mem_test_sva.sv
verification/mem_test_tb.sv

//--- Bender.yml
package:
  name: mem_test

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_chan_pkg.sv
      - rtl/test_csr_pkg.sv
      - rtl/csr_block.sv
      - rtl/run_control.sv
      - rtl/traffic_stream.sv
      - rtl/status_writer.sv
      - rtl/response_counters.sv
      - rtl/mem_test_top.sv
  - target: test
    files:
      - verification/mem_test_sva.sv
      - verification/mem_test_tb.sv
